// File: rtl/corr_cfg_pkg.sv
package corr_cfg_pkg;

  // Width of every byte port on the host side.
  localparam int BYTE_W = 8;

  // The command byte carries the opcode in its upper nibble and the argument in its lower.
  localparam int ARG_W = 4;
  localparam int OP_W  = BYTE_W - ARG_W;

  // Host command opcodes.
  // Codes above OP_READ are reserved and treated like OP_NOP.
  typedef enum logic [OP_W-1:0] {
    OP_NOP        = 4'h0,
    OP_SET_WINDOW = 4'h1,
    OP_SET_PERIOD = 4'h2,
    OP_FLUSH      = 4'h3,
    OP_READ       = 4'h4
  } corr_op_e;

  // Configuration that the block wakes up with.
  localparam logic [ARG_W-1:0] RESET_WINDOW_EXP = 4'd4;
  localparam logic [ARG_W-1:0] RESET_PERIOD_EXP = 4'd0;

endpackage

// File: rtl/corr_pkt_pkg.sv
package corr_pkt_pkg;

  // A packet is the window number followed by the four normalized counts.
  localparam int PKT_BYTES = 5;
  localparam int PKT_IDX_W = 3;

  // Byte positions inside a packet, in the order they enter the FIFO.
  typedef enum logic [PKT_IDX_W-1:0] {
    PB_WIN     = 3'd0,
    PB_X       = 3'd1,
    PB_Y       = 3'd2,
    PB_ISECT   = 3'd3,
    PB_SYMDIFF = 3'd4
  } pkt_byte_e;

  // A count equal to the full window length normalizes to 2^NORM_EXP.
  localparam int NORM_EXP = 7;

endpackage

// File: rtl/pkt_fifo_if.sv
interface pkt_fifo_if;

  // Write side, driven by the packet serializer.
  logic                            push;
  logic [corr_cfg_pkg::BYTE_W-1:0] push_data;
  logic                            room;

  // Read side, driven by the host register block.
  logic                            pop;
  logic [corr_cfg_pkg::BYTE_W-1:0] pop_data;
  logic                            empty;
  logic                            flush;

  modport producer (output push, output push_data, input room);

  modport consumer (output pop, output flush, input pop_data, input empty);

  modport store (
    input  push, input  push_data, input  pop, input  flush,
    output room, output pop_data,  output empty
  );

endinterface

// File: rtl/sample_strobe.sv
module sample_strobe #(
  parameter int MAX_SAMPLE_PERIOD_EXP = 15
) (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  input  logic [corr_cfg_pkg::ARG_W-1:0] i_period_exp,
  input  logic                           i_restart,
  output logic                           o_strobe
);

  localparam int CNT_W = MAX_SAMPLE_PERIOD_EXP;

  logic [CNT_W-1:0] period_m1;
  logic [CNT_W-1:0] cnt_q;
  logic             at_end;

  // The low period_exp bits set, so the counter runs through 2^period_exp states.
  assign period_m1 = ~({CNT_W{1'b1}} << i_period_exp);
  assign at_end    = (cnt_q == period_m1);

  // No sample in the restart cycle itself. The new period counts from the accepting edge.
  assign o_strobe = at_end && !i_restart;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt_q <= '0;
    end else if (i_restart || at_end) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

// File: rtl/corr_count_rect.sv
module corr_count_rect #(
  parameter int MAX_WINDOW_LENGTH_EXP = 12
) (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  input  logic                           i_strobe,
  input  logic                           i_restart,
  input  logic [corr_cfg_pkg::ARG_W-1:0] i_window_exp,
  input  logic                           i_x,
  input  logic                           i_y,
  output logic [MAX_WINDOW_LENGTH_EXP:0] o_count_x,
  output logic [MAX_WINDOW_LENGTH_EXP:0] o_count_y,
  output logic [MAX_WINDOW_LENGTH_EXP:0] o_count_isect,
  output logic [MAX_WINDOW_LENGTH_EXP:0] o_count_symdiff,
  output logic                           o_window_end
);

  localparam int T_W   = MAX_WINDOW_LENGTH_EXP;
  localparam int CNT_W = MAX_WINDOW_LENGTH_EXP + 1;
  localparam int N_CNT = 4;

  logic [T_W-1:0]              win_m1;
  logic [CNT_W-1:0]            win_len;
  logic [T_W-1:0]              t_q;
  logic                        last_sample;
  logic                        wrap_q;
  logic                        win_end_q;
  logic [N_CNT-1:0]            hit;
  logic [N_CNT-1:0][CNT_W-1:0] cnt_q;

  assign win_m1      = ~({T_W{1'b1}} << i_window_exp);
  assign win_len     = {1'b0, win_m1} + 1'b1;
  assign last_sample = i_strobe && (t_q == win_m1);

  // Same order as the count outputs.
  assign hit = {i_x ^ i_y, i_x & i_y, i_y, i_x};

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      t_q       <= '0;
      wrap_q    <= 1'b0;
      win_end_q <= 1'b0;
    end else if (i_restart) begin
      t_q       <= '0;
      wrap_q    <= 1'b0;
      win_end_q <= 1'b0;
    end else begin
      win_end_q <= last_sample;
      if (i_strobe) begin
        t_q    <= last_sample ? '0 : t_q + 1'b1;
        wrap_q <= last_sample;
      end
    end
  end

  // Final counts stay visible until the first sample of the next window lands.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt_q <= '0;
    end else if (i_restart) begin
      cnt_q <= '0;
    end else if (i_strobe) begin
      for (int k = 0; k < N_CNT; k++) begin
        cnt_q[k] <= (wrap_q ? '0 : cnt_q[k]) + CNT_W'(hit[k]);
      end
    end
  end

  assign o_count_x       = cnt_q[0];
  assign o_count_y       = cnt_q[1];
  assign o_count_isect   = cnt_q[2];
  assign o_count_symdiff = cnt_q[3];
  assign o_window_end    = win_end_q;

  // The window index must wrap before any count can pass the window length.
  assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (cnt_q[0] <= win_len) && (cnt_q[1] <= win_len) &&
    (cnt_q[2] <= win_len) && (cnt_q[3] <= win_len))
    else $error("corr_count_rect: count exceeds window length");

endmodule

// File: rtl/pkt_fifo.sv
module pkt_fifo #(
  parameter int PKT_FIFO_DEPTH = 20
) (
  input logic          i_clk,
  input logic          i_arst_n,
  pkt_fifo_if.store    fifo
);

  localparam int PTR_W = $clog2(PKT_FIFO_DEPTH);
  localparam int CNT_W = $clog2(PKT_FIFO_DEPTH + 1);

  localparam logic [CNT_W-1:0] DEPTH_C  = CNT_W'(PKT_FIFO_DEPTH);
  localparam logic [CNT_W-1:0] ROOM_MIN = CNT_W'(corr_pkt_pkg::PKT_BYTES);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(PKT_FIFO_DEPTH - 1);

  logic [corr_cfg_pkg::BYTE_W-1:0] mem [PKT_FIFO_DEPTH];
  logic [PTR_W-1:0]                wr_ptr_q;
  logic [PTR_W-1:0]                rd_ptr_q;
  logic [CNT_W-1:0]                count_q;
  logic                            full;
  logic                            do_push;
  logic                            do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  assign full          = (count_q == DEPTH_C);
  assign fifo.empty    = (count_q == '0);
  assign fifo.room     = (DEPTH_C - count_q) >= ROOM_MIN;
  assign fifo.pop_data = mem[rd_ptr_q];

  // A flush wins over a push or pop in the same cycle.
  assign do_push = fifo.push && !full && !fifo.flush;
  assign do_pop  = fifo.pop && !fifo.empty && !fifo.flush;

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= fifo.push_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (fifo.flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // The serializer only starts a packet when room was reported.
  assert property (@(posedge i_clk) disable iff (!i_arst_n) fifo.push |-> !full)
    else $error("pkt_fifo: push while full");

  assert property (@(posedge i_clk) disable iff (!i_arst_n) fifo.pop |-> !fifo.empty)
    else $error("pkt_fifo: pop while empty");

endmodule

// File: rtl/host_regs.sv
module host_regs #(
  parameter int MAX_WINDOW_LENGTH_EXP = 12,
  parameter int MAX_SAMPLE_PERIOD_EXP = 15
) (
  input  logic                            i_clk,
  input  logic                            i_arst_n,

  input  logic [corr_cfg_pkg::BYTE_W-1:0] i_bp_data,
  input  logic                            i_bp_valid,
  output logic                            o_bp_ready,

  output logic [corr_cfg_pkg::BYTE_W-1:0] o_bp_data,
  output logic                            o_bp_valid,
  input  logic                            i_bp_ready,

  output logic [corr_cfg_pkg::ARG_W-1:0]  o_window_exp,
  output logic [corr_cfg_pkg::ARG_W-1:0]  o_period_exp,
  output logic                            o_restart,

  pkt_fifo_if.consumer                    fifo
);

  localparam int ARG_W  = corr_cfg_pkg::ARG_W;
  localparam int BYTE_W = corr_cfg_pkg::BYTE_W;

  localparam logic [ARG_W-1:0] WINDOW_EXP_MAX = ARG_W'(MAX_WINDOW_LENGTH_EXP);
  localparam logic [ARG_W-1:0] PERIOD_EXP_MAX = ARG_W'(MAX_SAMPLE_PERIOD_EXP);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_DATA,
    REPLY
  } state_e;

  state_e                 state_q;
  corr_cfg_pkg::corr_op_e op;
  logic [ARG_W-1:0]       arg;
  logic                   cmd_fire;
  logic [ARG_W-1:0]       window_exp_q;
  logic [ARG_W-1:0]       period_exp_q;
  logic [BYTE_W-1:0]      reply_q;

  assign op  = corr_cfg_pkg::corr_op_e'(i_bp_data[BYTE_W-1:ARG_W]);
  assign arg = i_bp_data[ARG_W-1:0];

  // Commands are only taken while no read is outstanding.
  assign o_bp_ready = (state_q == IDLE);
  assign cmd_fire   = i_bp_valid && o_bp_ready;

  // Every configuration command also starts a fresh measurement run.
  always_comb begin
    o_restart = 1'b0;
    if (cmd_fire) begin
      case (op)
        corr_cfg_pkg::OP_SET_WINDOW,
        corr_cfg_pkg::OP_SET_PERIOD,
        corr_cfg_pkg::OP_FLUSH: o_restart = 1'b1;
        default:                o_restart = 1'b0;
      endcase
    end
  end

  assign fifo.flush = o_restart;
  assign fifo.pop   = (state_q == WAIT_DATA) && !fifo.empty;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      window_exp_q <= corr_cfg_pkg::RESET_WINDOW_EXP;
      period_exp_q <= corr_cfg_pkg::RESET_PERIOD_EXP;
    end else if (cmd_fire) begin
      if (op == corr_cfg_pkg::OP_SET_WINDOW) begin
        window_exp_q <= (arg > WINDOW_EXP_MAX) ? WINDOW_EXP_MAX : arg;
      end
      if (op == corr_cfg_pkg::OP_SET_PERIOD) begin
        period_exp_q <= (arg > PERIOD_EXP_MAX) ? PERIOD_EXP_MAX : arg;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (cmd_fire && (op == corr_cfg_pkg::OP_READ)) begin
            state_q <= WAIT_DATA;
          end
        end
        // Parks here until the serializer has written something.
        WAIT_DATA: begin
          if (!fifo.empty) begin
            state_q <= REPLY;
          end
        end
        REPLY: begin
          if (i_bp_ready) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (fifo.pop) begin
      reply_q <= fifo.pop_data;
    end
  end

  assign o_bp_valid   = (state_q == REPLY);
  assign o_bp_data    = reply_q;
  assign o_window_exp = window_exp_q;
  assign o_period_exp = period_exp_q;

  // A stalled reply byte must not change under the host.
  assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_bp_valid && !i_bp_ready |=> o_bp_valid && $stable(o_bp_data))
    else $error("host_regs: reply changed while stalled");

endmodule

// File: rtl/correlator.sv
module correlator #(
  parameter int MAX_WINDOW_LENGTH_EXP = 12,
  parameter int MAX_SAMPLE_PERIOD_EXP = 15,
  parameter int PKT_FIFO_DEPTH        = 20
) (
  input  logic                            i_clk,
  input  logic                            i_arst_n,

  input  logic                            i_x,
  input  logic                            i_y,

  input  logic [corr_cfg_pkg::BYTE_W-1:0] i_bp_data,
  input  logic                            i_bp_valid,
  output logic                            o_bp_ready,

  output logic [corr_cfg_pkg::BYTE_W-1:0] o_bp_data,
  output logic                            o_bp_valid,
  input  logic                            i_bp_ready
);

  localparam int ARG_W     = corr_cfg_pkg::ARG_W;
  localparam int BYTE_W    = corr_cfg_pkg::BYTE_W;
  localparam int PKT_BYTES = corr_pkt_pkg::PKT_BYTES;
  localparam int CNT_W     = MAX_WINDOW_LENGTH_EXP + 1;
  localparam int NORM_W    = CNT_W + corr_pkt_pkg::NORM_EXP;

  logic [ARG_W-1:0]                  window_exp;
  logic [ARG_W-1:0]                  period_exp;
  logic                              restart;
  logic                              strobe;
  logic [CNT_W-1:0]                  count_x;
  logic [CNT_W-1:0]                  count_y;
  logic [CNT_W-1:0]                  count_isect;
  logic [CNT_W-1:0]                  count_symdiff;
  logic                              window_end;
  logic [BYTE_W-1:0]                 win_num_q;
  logic [PKT_BYTES-1:0][BYTE_W-1:0]  pkt_d;
  logic [PKT_BYTES-1:0][BYTE_W-1:0]  pkt_q;
  corr_pkt_pkg::pkt_byte_e           idx_q;
  logic                              busy_q;
  logic                              pkt_load;

  pkt_fifo_if u_fifo_if ();

  host_regs #(
    .MAX_WINDOW_LENGTH_EXP (MAX_WINDOW_LENGTH_EXP),
    .MAX_SAMPLE_PERIOD_EXP (MAX_SAMPLE_PERIOD_EXP)
  ) u_host_regs (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_bp_data    (i_bp_data),
    .i_bp_valid   (i_bp_valid),
    .o_bp_ready   (o_bp_ready),
    .o_bp_data    (o_bp_data),
    .o_bp_valid   (o_bp_valid),
    .i_bp_ready   (i_bp_ready),
    .o_window_exp (window_exp),
    .o_period_exp (period_exp),
    .o_restart    (restart),
    .fifo         (u_fifo_if.consumer)
  );

  sample_strobe #(
    .MAX_SAMPLE_PERIOD_EXP (MAX_SAMPLE_PERIOD_EXP)
  ) u_sample_strobe (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_period_exp (period_exp),
    .i_restart    (restart),
    .o_strobe     (strobe)
  );

  corr_count_rect #(
    .MAX_WINDOW_LENGTH_EXP (MAX_WINDOW_LENGTH_EXP)
  ) u_count_rect (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_strobe        (strobe),
    .i_restart       (restart),
    .i_window_exp    (window_exp),
    .i_x             (i_x),
    .i_y             (i_y),
    .o_count_x       (count_x),
    .o_count_y       (count_y),
    .o_count_isect   (count_isect),
    .o_count_symdiff (count_symdiff),
    .o_window_end    (window_end)
  );

  pkt_fifo #(
    .PKT_FIFO_DEPTH (PKT_FIFO_DEPTH)
  ) u_pkt_fifo (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .fifo     (u_fifo_if.store)
  );

  // Scales a count to 0..128, with a full window mapping to 128.
  function automatic logic [BYTE_W-1:0] norm_byte(
    input logic [CNT_W-1:0] count,
    input logic [ARG_W-1:0] win_exp
  );
    logic [NORM_W-1:0] scaled;
    scaled = {count, {corr_pkt_pkg::NORM_EXP{1'b0}}} >> win_exp;
    return scaled[BYTE_W-1:0];
  endfunction

  always_comb begin
    pkt_d[corr_pkt_pkg::PB_WIN]     = win_num_q;
    pkt_d[corr_pkt_pkg::PB_X]       = norm_byte(count_x, window_exp);
    pkt_d[corr_pkt_pkg::PB_Y]       = norm_byte(count_y, window_exp);
    pkt_d[corr_pkt_pkg::PB_ISECT]   = norm_byte(count_isect, window_exp);
    pkt_d[corr_pkt_pkg::PB_SYMDIFF] = norm_byte(count_symdiff, window_exp);
  end

  // A packet is dropped when the FIFO is short of space or the last one is still going out.
  assign pkt_load = window_end && u_fifo_if.room && !busy_q;

  // The window number advances on every window, so a gap shows a dropped packet.
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      win_num_q <= '0;
    end else if (restart) begin
      win_num_q <= '0;
    end else if (window_end) begin
      win_num_q <= win_num_q + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (pkt_load) begin
      pkt_q <= pkt_d;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy_q <= 1'b0;
      idx_q  <= corr_pkt_pkg::PB_WIN;
    end else if (restart) begin
      busy_q <= 1'b0;
      idx_q  <= corr_pkt_pkg::PB_WIN;
    end else if (pkt_load) begin
      busy_q <= 1'b1;
      idx_q  <= corr_pkt_pkg::PB_WIN;
    end else if (busy_q) begin
      if (idx_q == corr_pkt_pkg::PB_SYMDIFF) begin
        busy_q <= 1'b0;
        idx_q  <= corr_pkt_pkg::PB_WIN;
      end else begin
        idx_q <= corr_pkt_pkg::pkt_byte_e'(idx_q + 1'b1);
      end
    end
  end

  // One byte per cycle while the serializer is busy.
  assign u_fifo_if.push      = busy_q;
  assign u_fifo_if.push_data = pkt_q[idx_q];

endmodule

// File: dv/tb_clkgen.sv
module tb_clkgen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic o_clk,
  output logic o_arst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // Reset is released just after a rising edge, clear of the sampling point.
  initial begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #2;
    o_arst_n = 1'b1;
  end

endmodule

// File: dv/tb_correlator.sv
module tb_correlator;

  localparam int          CLK_PERIOD     = 20;
  localparam int          HIST_LEN       = 1 << 15;
  localparam logic [31:0] SEED           = 32'hea9b3f1b;
  localparam int          N_TESTS        = 8;
  localparam int          T_CONST_XY     = 1;
  localparam int          T_FLUSH        = 5;
  localparam int          T_BACKPRESSURE = 6;
  localparam int          T_OVERFLOW     = 7;
  localparam int          OVF_IDLE_WIN   = 12;
  localparam int          BYTE_W         = corr_cfg_pkg::BYTE_W;
  localparam int          ARG_W          = corr_cfg_pkg::ARG_W;

  typedef logic [corr_pkt_pkg::PKT_BYTES-1:0][BYTE_W-1:0] pkt_t;

  typedef struct packed {
    logic [7:0]       n_win;
    logic [ARG_W-1:0] we;
    logic [ARG_W-1:0] pe;
  } cfg_t;

  typedef struct packed {
    int   rst_cyc;
    int   win;
    cfg_t cfg;
    pkt_t got;
  } rx_t;

  logic              clk;
  logic              arst_n;
  logic              x;
  logic              y;
  logic [BYTE_W-1:0] cmd_data;
  logic              cmd_valid;
  logic              cmd_ready;
  logic [BYTE_W-1:0] rsp_data;
  logic              rsp_valid;
  logic              rsp_ready;

  int                cyc;
  int                err_cnt;
  logic [31:0]       rnd_word;
  logic              stream_rand;
  logic              const_x;
  logic              const_y;
  logic              bp_mode;
  logic              x_hist [HIST_LEN];
  logic              y_hist [HIST_LEN];
  rx_t               rx_q [$];

  tb_clkgen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (10)
  ) u_clkgen (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  correlator i_correlator (
    .i_clk      (clk),
    .i_arst_n   (arst_n),
    .i_x        (x),
    .i_y        (y),
    .i_bp_data  (cmd_data),
    .i_bp_valid (cmd_valid),
    .o_bp_ready (cmd_ready),
    .o_bp_data  (rsp_data),
    .o_bp_valid (rsp_valid),
    .i_bp_ready (rsp_ready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Window count, window_exp and period_exp of each test.
  function automatic cfg_t test_cfg(input int t);
    case (t)
      0, 1:           return '{n_win: 8'd3, we: 4'd4, pe: 4'd1};
      2:              return '{n_win: 8'd4, we: 4'd3, pe: 4'd2};
      3:              return '{n_win: 8'd4, we: 4'd5, pe: 4'd0};
      4:              return '{n_win: 8'd4, we: 4'd6, pe: 4'd1};
      T_FLUSH:        return '{n_win: 8'd5, we: 4'd4, pe: 4'd2};
      T_BACKPRESSURE: return '{n_win: 8'd4, we: 4'd5, pe: 4'd2};
      default:        return '{n_win: 8'd20, we: 4'd3, pe: 4'd1};
    endcase
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0:              return "constant x=1 y=0";
      T_CONST_XY:     return "constant x=1 y=1";
      T_FLUSH:        return "window numbering after flush";
      T_BACKPRESSURE: return "reply back-pressure";
      T_OVERFLOW:     return "FIFO overflow";
      default:        return "random streams";
    endcase
  endfunction

  // Sample k of a run lands on edge rst_cyc + k * 2^pe and sees the value driven one
  // cycle earlier. Window w holds samples w * 2^we + 1 to (w + 1) * 2^we.
  function automatic pkt_t ref_packet(input int rst_cyc, input int pe, input int we,
                                      input int win);
    pkt_t p;
    int   len;
    int   per;
    int   idx;
    int   n_x;
    int   n_y;
    int   n_i;
    int   n_s;
    len = 1 << we;
    per = 1 << pe;
    n_x = 0;
    n_y = 0;
    n_i = 0;
    n_s = 0;
    for (int s = 1; s <= len; s++) begin
      idx = rst_cyc + (win * len + s) * per - 1;
      if (x_hist[idx]) n_x++;
      if (y_hist[idx]) n_y++;
      if (x_hist[idx] && y_hist[idx]) n_i++;
      if (x_hist[idx] != y_hist[idx]) n_s++;
    end
    p[corr_pkt_pkg::PB_WIN]     = 8'(win);
    p[corr_pkt_pkg::PB_X]       = 8'((n_x * 128) / len);
    p[corr_pkt_pkg::PB_Y]       = 8'((n_y * 128) / len);
    p[corr_pkt_pkg::PB_ISECT]   = 8'((n_i * 128) / len);
    p[corr_pkt_pkg::PB_SYMDIFF] = 8'((n_s * 128) / len);
    return p;
  endfunction

  task automatic check_byte(input corr_pkt_pkg::pkt_byte_e field,
                            input logic [BYTE_W-1:0] exp, input logic [BYTE_W-1:0] got);
    if (got !== exp) begin
      $display("Error at %0t: o_bp_data[%s] expected %0d, got %0d",
               $time, field.name(), exp, got);
      err_cnt++;
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // The value driven after edge n is recorded at index n.
  always @(posedge clk) begin
    #2;
    rnd_word = lcg_next(rnd_word);
    x = stream_rand ? rnd_word[31] : const_x;
    y = stream_rand ? rnd_word[30] : const_y;
    if (cyc < HIST_LEN) begin
      x_hist[cyc] = x;
      y_hist[cyc] = y;
    end
  end

  always @(negedge clk) begin : compare
    rx_t  r;
    pkt_t exp;
    while (rx_q.size() > 0) begin
      r   = rx_q.pop_front();
      exp = ref_packet(r.rst_cyc, int'(r.cfg.pe), int'(r.cfg.we), r.win);
      for (int b = 0; b < corr_pkt_pkg::PKT_BYTES; b++) begin
        check_byte(corr_pkt_pkg::pkt_byte_e'(b), exp[b], r.got[b]);
      end
    end
  end

  // Tasks below start and end 2 units after a rising edge.
  task automatic send_cmd(input corr_cfg_pkg::corr_op_e op, input logic [ARG_W-1:0] arg,
                          output int acc_cyc);
    cmd_data  = {op, arg};
    cmd_valid = 1'b1;
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    @(posedge clk);
    #2;
    acc_cyc   = cyc;
    cmd_valid = 1'b0;
  endtask

  task automatic configure_run(input cfg_t c, output int rst_cyc);
    send_cmd(corr_cfg_pkg::OP_SET_WINDOW, c.we, rst_cyc);
    send_cmd(corr_cfg_pkg::OP_SET_PERIOD, c.pe, rst_cyc);
  endtask

  task automatic read_byte(output logic [BYTE_W-1:0] data);
    int                acc;
    int                stall;
    logic [BYTE_W-1:0] held;
    logic              seen;
    logic              done;
    send_cmd(corr_cfg_pkg::OP_READ, '0, acc);
    seen = 1'b0;
    done = 1'b0;
    held = '0;
    @(negedge clk);
    stall = bp_mode ? int'(rnd_word[27:25]) : 0;
    while (!done) begin
      @(posedge clk);
      #2;
      rsp_ready = (stall == 0);
      if (stall > 0) stall--;
      @(negedge clk);
      // The command port stays closed until the reply byte has been taken.
      if (cmd_ready !== 1'b0) begin
        $display("Error at %0t: o_bp_ready expected 0, got %0b", $time, cmd_ready);
        err_cnt++;
      end
      if (rsp_valid) begin
        if (seen && (rsp_data !== held)) begin
          $display("Error at %0t: o_bp_data changed while stalled, held %0d, now %0d",
                   $time, held, rsp_data);
          err_cnt++;
        end
        seen = 1'b1;
        held = rsp_data;
        if (rsp_ready) begin
          data = rsp_data;
          done = 1'b1;
        end
      end
    end
    @(posedge clk);
    #2;
  endtask

  task automatic read_packet(output pkt_t p);
    logic [BYTE_W-1:0] v;
    for (int b = 0; b < corr_pkt_pkg::PKT_BYTES; b++) begin
      read_byte(v);
      p[b] = v;
    end
  endtask

  task automatic queue_check(input int rst_cyc, input cfg_t c, input int win, input pkt_t got);
    rx_q.push_back('{rst_cyc: rst_cyc, win: win, cfg: c, got: got});
  endtask

  task automatic read_windows(input int rst_cyc, input cfg_t c, input int first, input int n);
    pkt_t got;
    for (int i = 0; i < n; i++) begin
      read_packet(got);
      queue_check(rst_cyc, c, first + i, got);
    end
  endtask

  task automatic run_test(input int t);
    cfg_t c;
    int   rst_cyc;
    int   flush_cyc;
    int   idle;
    pkt_t got;
    c           = test_cfg(t);
    bp_mode     = (t == T_BACKPRESSURE);
    stream_rand = (t > T_CONST_XY);
    const_x     = 1'b1;
    const_y     = (t == T_CONST_XY);
    configure_run(c, rst_cyc);
    case (t)
      T_FLUSH: begin
        read_windows(rst_cyc, c, 0, 2);
        send_cmd(corr_cfg_pkg::OP_FLUSH, '0, flush_cyc);
        read_windows(flush_cyc, c, 0, 3);
      end
      T_OVERFLOW: begin
        idle = OVF_IDLE_WIN * (1 << (int'(c.we) + int'(c.pe)));
        repeat (idle) @(posedge clk);
        #2;
        read_windows(rst_cyc, c, 0, 4);
        read_packet(got);
        if (got[corr_pkt_pkg::PB_WIN] <= 8'd4) begin
          $display("Overflow: window %0d followed window 3, so nothing was dropped",
                   got[corr_pkt_pkg::PB_WIN]);
          err_cnt++;
        end
        queue_check(rst_cyc, c, int'(got[corr_pkt_pkg::PB_WIN]), got);
        send_cmd(corr_cfg_pkg::OP_FLUSH, '0, flush_cyc);
        read_windows(flush_cyc, c, 0, 1);
      end
      default: read_windows(rst_cyc, c, 0, int'(c.n_win));
    endcase
    // Gives the compare process a falling edge to drain the queue.
    repeat (2) @(posedge clk);
    #2;
  endtask

  initial begin : watchdog
    cfg_t   c;
    longint budget;
    budget = 0;
    for (int t = 0; t < N_TESTS; t++) begin
      c      = test_cfg(t);
      budget = budget + longint'(c.n_win) * (longint'(1) << c.we) * (longint'(1) << c.pe) *
               longint'(CLK_PERIOD);
    end
    budget = budget * longint'(4);
    #(budget);
    $display("Simulation timed out at %0t before all tests finished", $time);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main
    int n_failed;
    int errs_before;
    x           = 1'b0;
    y           = 1'b0;
    cmd_data    = '0;
    cmd_valid   = 1'b0;
    rsp_ready   = 1'b1;
    cyc         = 0;
    err_cnt     = 0;
    n_failed    = 0;
    rnd_word    = SEED;
    stream_rand = 1'b1;
    const_x     = 1'b0;
    const_y     = 1'b0;
    bp_mode     = 1'b0;
    @(posedge arst_n);
    @(posedge clk);
    #2;
    for (int t = 0; t < N_TESTS; t++) begin
      errs_before = err_cnt;
      run_test(t);
      if (err_cnt != errs_before) begin
        n_failed++;
      end
      $display("Test %0d (%s): %s", t, test_name(t), (err_cnt == errs_before) ? "ok" : "FAILED");
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", N_TESTS, n_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: filelist.f
rtl/corr_cfg_pkg.sv
rtl/corr_pkt_pkg.sv
rtl/pkt_fifo_if.sv
rtl/sample_strobe.sv
rtl/corr_count_rect.sv
rtl/pkt_fifo.sv
rtl/host_regs.sv
rtl/correlator.sv
dv/tb_clkgen.sv
dv/tb_correlator.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_correlator
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := *** TEST PASSED ***

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
